/* common/cache_pkg.sv */
// word width fixed at 32 bits; the controller state encoding needs 2 bits
package cache_pkg;

	// ----------------------------------------
	// processor word
	// ----------------------------------------

	// one processor word, the unit of proc_rdata and proc_wdata
	localparam int DATA_W = 32;

	typedef logic [DATA_W-1:0] word_t;

	// ----------------------------------------
	// miss controller states
	// ----------------------------------------

	// CS_IDLE serves hits and detects misses
	// CS_WRITE_BACK pushes a dirty victim line to memory
	// CS_ALLOCATE fetches the requested line from memory
	typedef enum logic [1:0] {
		CS_IDLE       = 2'b00,
		CS_WRITE_BACK = 2'b01,
		CS_ALLOCATE   = 2'b10
	} cache_state_e;

endpackage

/* cache/cache_store.sv */
// direct mapped line store; NUM_SETS and LINE_WORDS must be powers of two and at least 2
`timescale 1ns/1ps

module cache_store
	import cache_pkg::*;
#(
	parameter int ADDR_W     = 30,
	parameter int NUM_SETS   = 8,
	parameter int LINE_WORDS = 4
) (
	input  logic                                   clk,
	input  logic                                   proc_reset,

	// request side
	input  logic [ADDR_W-1:0]                      proc_addr,
	input  word_t                                  proc_wdata,
	output word_t                                  proc_rdata,

	// from the controller
	input  logic                                   word_we,
	input  logic                                   line_fill,

	// to the controller
	output logic                                   hit,
	output logic                                   victim_dirty,
	output logic [ADDR_W-$clog2(LINE_WORDS)-1:0]   victim_line_addr,

	// line data to and from memory
	input  logic [LINE_WORDS*DATA_W-1:0]           mem_rdata,
	output logic [LINE_WORDS*DATA_W-1:0]           mem_wdata
);

	localparam int OFF_W  = $clog2(LINE_WORDS);
	localparam int IDX_W  = $clog2(NUM_SETS);
	localparam int TAG_W  = ADDR_W - IDX_W - OFF_W;

	// ----------------------------------------
	// address split
	// ----------------------------------------

	logic [OFF_W-1:0] req_off;   // word within line
	logic [IDX_W-1:0] req_idx;   // set select
	logic [TAG_W-1:0] req_tag;

	assign req_off = proc_addr[OFF_W-1:0];
	assign req_idx = proc_addr[OFF_W +: IDX_W];
	assign req_tag = proc_addr[ADDR_W-1 -: TAG_W];

	// ----------------------------------------
	// storage
	// ----------------------------------------

	logic [NUM_SETS-1:0] valid_q;
	logic [NUM_SETS-1:0] dirty_q;
	logic [TAG_W-1:0]    tag_q  [NUM_SETS];
	word_t               data_q [NUM_SETS][LINE_WORDS];

	logic [TAG_W-1:0]    cur_tag;                 // tag of the indexed line
	word_t               line_next [LINE_WORDS];  // line to be written back into data_q

	assign cur_tag = tag_q[req_idx];

	// ----------------------------------------
	// lookup
	// ----------------------------------------

	assign hit          = valid_q[req_idx] && (cur_tag == req_tag);
	assign victim_dirty = valid_q[req_idx] && dirty_q[req_idx];

	// victim sits at the same index, only the tag can differ
	assign victim_line_addr = {cur_tag, req_idx};

	assign proc_rdata = data_q[req_idx][req_off];

	// flatten the indexed line for write back
	always_comb begin
		mem_wdata = '0;
		for (int w = 0; w < LINE_WORDS; w++) begin
			mem_wdata[w*DATA_W +: DATA_W] = data_q[req_idx][w];
		end
	end

	// ----------------------------------------
	// line update
	// ----------------------------------------

	// a fill takes the whole memory line
	// a word write keeps the line and swaps one word
	always_comb begin
		for (int w = 0; w < LINE_WORDS; w++) begin
			if (line_fill) begin
				line_next[w] = mem_rdata[w*DATA_W +: DATA_W];
			end else if (w == int'(req_off)) begin
				line_next[w] = proc_wdata;
			end else begin
				line_next[w] = data_q[req_idx][w];
			end
		end
	end

	// payload arrays
	always_ff @(posedge clk) begin
		if (line_fill) begin
			tag_q[req_idx]  <= req_tag;
			data_q[req_idx] <= line_next;
		end else if (word_we) begin
			data_q[req_idx] <= line_next;
		end
	end

	// every line starts invalid and clean
	always_ff @(posedge clk or posedge proc_reset) begin
		if (proc_reset) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else if (line_fill) begin
			valid_q[req_idx] <= 1'b1;
			dirty_q[req_idx] <= 1'b0;   // fresh copy of memory
		end else if (word_we) begin
			dirty_q[req_idx] <= 1'b1;
		end
	end

endmodule

/* cache/cache_ctrl.sv */
// one request in flight; read and write together count as no request; caller holds it while stalled
`timescale 1ns/1ps

module cache_ctrl
	import cache_pkg::*;
#(
	parameter int ADDR_W     = 30,
	parameter int NUM_SETS   = 8,
	parameter int LINE_WORDS = 4
) (
	input  logic                                   clk,
	input  logic                                   proc_reset,

	// processor request
	input  logic                                   proc_read,
	input  logic                                   proc_write,
	input  logic [ADDR_W-1:0]                      proc_addr,
	output logic                                   proc_stall,

	// store status and commands
	input  logic                                   hit,
	input  logic                                   victim_dirty,
	input  logic [ADDR_W-$clog2(LINE_WORDS)-1:0]   victim_line_addr,
	output logic                                   word_we,
	output logic                                   line_fill,

	// memory handshake
	input  logic                                   mem_ready,
	output logic                                   mem_read,
	output logic                                   mem_write,
	output logic [ADDR_W-$clog2(LINE_WORDS)-1:0]   mem_addr
);

	localparam int OFF_W = $clog2(LINE_WORDS);
	localparam int IDX_W = $clog2(NUM_SETS);
	localparam int TAG_W = ADDR_W - IDX_W - OFF_W;

	// ----------------------------------------
	// request decode
	// ----------------------------------------

	cache_state_e     state_q;
	cache_state_e     state_d;

	logic             req_valid;   // exactly one of read or write
	logic             req_wr;
	logic             miss;
	logic [IDX_W-1:0] req_idx;
	logic [TAG_W-1:0] req_tag;

	assign req_valid = proc_read ^ proc_write;
	assign req_wr    = proc_write && !proc_read;
	assign miss      = req_valid && !hit;

	assign req_idx = proc_addr[OFF_W +: IDX_W];
	assign req_tag = proc_addr[ADDR_W-1 -: TAG_W];

	// ----------------------------------------
	// next state
	// ----------------------------------------

	always_comb begin
		state_d = state_q;
		case (state_q)
			CS_IDLE: begin
				if (miss) begin
					// clean or invalid victim skips the write back
					state_d = victim_dirty ? CS_WRITE_BACK : CS_ALLOCATE;
				end
			end
			CS_WRITE_BACK: begin
				if (mem_ready) begin
					state_d = CS_ALLOCATE;
				end
			end
			CS_ALLOCATE: begin
				if (mem_ready) begin
					state_d = CS_IDLE;   // request hits on the next cycle
				end
			end
			default: begin
				state_d = CS_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or posedge proc_reset) begin
		if (proc_reset) begin
			state_q <= CS_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// ----------------------------------------
	// outputs
	// ----------------------------------------

	// all outputs follow the state, so a low mem_ready holds them
	always_comb begin
		proc_stall = 1'b0;
		word_we    = 1'b0;
		line_fill  = 1'b0;
		mem_read   = 1'b0;
		mem_write  = 1'b0;
		mem_addr   = {req_tag, req_idx};   // line address of the request
		case (state_q)
			CS_IDLE: begin
				proc_stall = miss;           // high in the request cycle
				word_we    = req_wr && hit;
			end
			CS_WRITE_BACK: begin
				proc_stall = 1'b1;
				mem_write  = 1'b1;
				mem_addr   = victim_line_addr;
			end
			CS_ALLOCATE: begin
				proc_stall = 1'b1;
				mem_read   = 1'b1;
				line_fill  = mem_ready;      // mem_rdata valid this cycle
			end
			default: begin
				proc_stall = 1'b0;
			end
		endcase
	end

endmodule

/* src/cache_top.sv */
// direct mapped write-back write-allocate cache; line-wide memory port held until mem_ready
`timescale 1ns/1ps

module cache_top
	import cache_pkg::*;
#(
	parameter int ADDR_W     = 30,   // word address
	parameter int NUM_SETS   = 8,
	parameter int LINE_WORDS = 4
) (
	input  logic                                   clk,
	input  logic                                   proc_reset,

	// ----------------------------------------
	// processor port
	// ----------------------------------------
	input  logic                                   proc_read,
	input  logic                                   proc_write,
	input  logic [ADDR_W-1:0]                      proc_addr,
	input  word_t                                  proc_wdata,
	output logic                                   proc_stall,
	output word_t                                  proc_rdata,

	// ----------------------------------------
	// memory port
	// ----------------------------------------
	output logic                                   mem_read,
	output logic                                   mem_write,
	output logic [ADDR_W-$clog2(LINE_WORDS)-1:0]   mem_addr,    // line address
	output logic [LINE_WORDS*DATA_W-1:0]           mem_wdata,
	input  logic [LINE_WORDS*DATA_W-1:0]           mem_rdata,
	input  logic                                   mem_ready
);

	// store to controller
	logic                                 hit;
	logic                                 victim_dirty;
	logic [ADDR_W-$clog2(LINE_WORDS)-1:0] victim_line_addr;

	// controller to store
	logic                                 word_we;
	logic                                 line_fill;

	cache_store #(
		.ADDR_W     (ADDR_W),
		.NUM_SETS   (NUM_SETS),
		.LINE_WORDS (LINE_WORDS)
	) u_store (
		.clk              (clk),
		.proc_reset       (proc_reset),
		.proc_addr        (proc_addr),
		.proc_wdata       (proc_wdata),
		.proc_rdata       (proc_rdata),
		.word_we          (word_we),
		.line_fill        (line_fill),
		.hit              (hit),
		.victim_dirty     (victim_dirty),
		.victim_line_addr (victim_line_addr),
		.mem_rdata        (mem_rdata),
		.mem_wdata        (mem_wdata)
	);

	cache_ctrl #(
		.ADDR_W     (ADDR_W),
		.NUM_SETS   (NUM_SETS),
		.LINE_WORDS (LINE_WORDS)
	) u_ctrl (
		.clk              (clk),
		.proc_reset       (proc_reset),
		.proc_read        (proc_read),
		.proc_write       (proc_write),
		.proc_addr        (proc_addr),
		.proc_stall       (proc_stall),
		.hit              (hit),
		.victim_dirty     (victim_dirty),
		.victim_line_addr (victim_line_addr),
		.word_we          (word_we),
		.line_fill        (line_fill),
		.mem_ready        (mem_ready),
		.mem_read         (mem_read),
		.mem_write        (mem_write),
		.mem_addr         (mem_addr)
	);

endmodule

/* test/mem_model.sv */
// line-wide memory for the first NUM_LINES lines only; ready comes wait_cycles cycles after a request
`timescale 1ns/1ps

module mem_model
	import cache_pkg::*;
#(
	parameter int LINE_ADDR_W = 28,
	parameter int LINE_WORDS  = 4,
	parameter int NUM_LINES   = 64
) (
	input  logic                          clk,
	input  logic                          proc_reset,
	input  logic                          mem_read,
	input  logic                          mem_write,
	input  logic [LINE_ADDR_W-1:0]        mem_addr,
	input  logic [LINE_WORDS*DATA_W-1:0]  mem_wdata,
	output logic [LINE_WORDS*DATA_W-1:0]  mem_rdata,
	output logic                          mem_ready,
	input  logic [1:0]                    wait_cycles,   // sampled when a request starts
	output int                            error_count
);

	localparam int SLOT_W = $clog2(NUM_LINES);

	logic [LINE_WORDS*DATA_W-1:0] lines [NUM_LINES];
	logic                         busy;
	int                           count;
	logic [LINE_ADDR_W-1:0]       held_addr;
	logic [LINE_WORDS*DATA_W-1:0] held_wdata;
	logic                         held_write;

	// same pattern as the golden model in tb_cache
	function automatic word_t fill_word(input int unsigned word_addr);
		return (word_addr * 32'h9e3779b1) ^ 32'h6a09e667;
	endfunction

	initial begin
		for (int l = 0; l < NUM_LINES; l++) begin
			for (int w = 0; w < LINE_WORDS; w++) begin
				lines[l][w*DATA_W +: DATA_W] = fill_word(l * LINE_WORDS + w);
			end
		end
		mem_ready   = 1'b0;
		mem_rdata   = '0;
		busy        = 1'b0;
		count       = 0;
		error_count = 0;
	end

	// ----------------------------------------
	// responder driven on the falling edge
	// ----------------------------------------

	always @(negedge clk or posedge proc_reset) begin
		if (proc_reset) begin
			mem_ready <= 1'b0;
			busy = 1'b0;
			count = 0;
		end else begin
			if (mem_ready) begin
				busy = 1'b0;   // transfer ended at the last rising edge
			end
			if (!busy && (mem_read || mem_write)) begin
				busy       = 1'b1;
				count      = wait_cycles;
				held_addr  = mem_addr;
				held_wdata = mem_wdata;
				held_write = mem_write;
			end else if (busy) begin
				// back-pressure must freeze the whole request
				assert ((mem_read ^ mem_write) && mem_write == held_write && mem_addr == held_addr
					&& (!held_write || mem_wdata == held_wdata)) else begin
					error_count++;
					$display("ERROR %0t ns: memory request changed while waiting for ready", $time);
				end
			end
			if (busy && count == 0) begin
				mem_ready <= 1'b1;
				if (mem_read) begin
					mem_rdata <= lines[mem_addr[SLOT_W-1:0]];
				end
				if (mem_write) begin
					lines[mem_addr[SLOT_W-1:0]] = mem_wdata;
				end
			end else begin
				mem_ready <= 1'b0;
				if (busy) begin
					count--;
				end
			end
		end
	end

endmodule

/* test/tb_cache.sv */
// default cache geometry only; word addresses stay below 256 so 64 lines fold onto 8 sets
`timescale 1ns/1ps

module tb_cache
	import cache_pkg::*;
();

	localparam int CLK_PERIOD = 100;
	localparam int ADDR_W     = 30;
	localparam int NUM_SETS   = 8;
	localparam int LINE_WORDS = 4;
	localparam int OFF_W      = 2;
	localparam int IDX_W      = 3;
	localparam int TAG_W      = ADDR_W - IDX_W - OFF_W;
	localparam int LADDR_W    = ADDR_W - OFF_W;
	localparam int LINE_W     = LINE_WORDS * DATA_W;
	localparam int NUM_WORDS  = 256;
	localparam int NUM_REQ    = 400;
	localparam int MAX_WAIT   = 3;
	localparam int WORST_CYC  = 2 * (MAX_WAIT + 1) + 2;   // request, write back, fill, hit

	logic               clk;
	logic               proc_reset;
	logic               proc_read;
	logic               proc_write;
	logic [ADDR_W-1:0]  proc_addr;
	word_t              proc_wdata;
	word_t              proc_rdata;
	logic               proc_stall;
	logic               mem_read;
	logic               mem_write;
	logic               mem_ready;
	logic [LADDR_W-1:0] mem_addr;
	logic [LINE_W-1:0]  mem_wdata;
	logic [LINE_W-1:0]  mem_rdata;
	logic [1:0]         mem_wait;
	int                 mem_errors;

	logic [31:0]        lfsr_q;
	word_t              golden [NUM_WORDS];
	logic               model_valid [NUM_SETS];   // expected cache contents
	logic               model_dirty [NUM_SETS];
	logic [TAG_W-1:0]   model_tag [NUM_SETS];
	int                 errors;
	int                 checks;

	initial clk = 1'b0;
	always #(CLK_PERIOD/2) clk = ~clk;

	cache_top DUT (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_read  (proc_read),
		.proc_write (proc_write),
		.proc_addr  (proc_addr),
		.proc_wdata (proc_wdata),
		.proc_stall (proc_stall),
		.proc_rdata (proc_rdata),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_rdata  (mem_rdata),
		.mem_ready  (mem_ready)
	);

	mem_model u_mem (
		.clk         (clk),
		.proc_reset  (proc_reset),
		.mem_read    (mem_read),
		.mem_write   (mem_write),
		.mem_addr    (mem_addr),
		.mem_wdata   (mem_wdata),
		.mem_rdata   (mem_rdata),
		.mem_ready   (mem_ready),
		.wait_cycles (mem_wait),
		.error_count (mem_errors)
	);

	// ----------------------------------------
	// helpers
	// ----------------------------------------

	// galois lfsr stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = {1'b0, lfsr_q[31:1]} ^ (lfsr_q[0] ? 32'ha3000000 : 32'h0);
			val = {val[30:0], lfsr_q[0]};
		end
		return val;
	endfunction

	function automatic word_t fill_word(input int unsigned word_addr);
		return (word_addr * 32'h9e3779b1) ^ 32'h6a09e667;
	endfunction

	function automatic logic [LINE_W-1:0] golden_line(input logic [LADDR_W-1:0] laddr);
		logic [LINE_W-1:0] line;
		for (int w = 0; w < LINE_WORDS; w++) begin
			line[w*DATA_W +: DATA_W] = golden[laddr[5:0] * LINE_WORDS + w];
		end
		return line;
	endfunction

	task automatic check_true(input string what, input logic cond);
		checks++;
		assert (cond === 1'b1) else begin
			errors++;
			$display("ERROR %0t ns: %s", $time, what);
		end
	endtask

	task automatic check_value(input string what, input logic [LINE_W-1:0] got,
		input logic [LINE_W-1:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("ERROR %0t ns: %s got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	// drives one request and follows it to completion, sampling on the rising edge
	task automatic run_request(input logic is_write, input logic [ADDR_W-1:0] addr,
		input word_t wdata);
		logic [IDX_W-1:0] idx;
		logic [TAG_W-1:0] tag;
		logic             exp_hit;
		logic             exp_wb;
		logic             first;
		logic             done;
		logic             seen_mem;
		idx     = addr[OFF_W +: IDX_W];
		tag     = addr[ADDR_W-1 -: TAG_W];
		exp_hit = model_valid[idx] && model_tag[idx] == tag;
		exp_wb  = !exp_hit && model_valid[idx] && model_dirty[idx];
		@(negedge clk);
		proc_read  = !is_write;
		proc_write = is_write;
		proc_addr  = addr;
		proc_wdata = wdata;
		first      = 1'b1;
		done       = 1'b0;
		seen_mem   = 1'b0;
		while (!done) begin
			@(posedge clk);
			if (first) begin
				check_true(exp_hit ? "hit stalled" : "miss did not stall", proc_stall == !exp_hit);
			end
			if ((mem_read || mem_write) && !seen_mem) begin
				seen_mem = 1'b1;
				check_true(exp_wb ? "dirty victim not written back first"
					: "clean victim not skipped", exp_wb ? mem_write : mem_read);
			end
			if (mem_write && mem_ready) begin
				check_true("write-back index differs from request", mem_addr[IDX_W-1:0] == idx);
				check_true("write-back tag equals request tag", mem_addr[LADDR_W-1 -: TAG_W] != tag);
				check_value("write-back line", mem_wdata, golden_line(mem_addr));
			end
			if (mem_read && mem_ready) begin
				check_true("line read at wrong address", mem_addr == addr[ADDR_W-1:OFF_W]);
			end
			if (!proc_stall) begin
				done = 1'b1;
				if (is_write) begin
					golden[addr[7:0]] = wdata;
				end else begin
					check_value("read data", proc_rdata, golden[addr[7:0]]);
				end
			end
			first    = 1'b0;
			mem_wait = rand_bits(2);   // taken by the memory at the next falling edge
		end
		if (!exp_hit) begin
			model_valid[idx] = 1'b1;
			model_tag[idx]   = tag;
			model_dirty[idx] = 1'b0;
		end
		if (is_write) begin
			model_dirty[idx] = 1'b1;
		end
	endtask

	// ----------------------------------------
	// stimulus
	// ----------------------------------------

	initial begin : main
		logic [31:0]       line;
		logic [31:0]       off;
		logic              is_write;
		logic [ADDR_W-1:0] addr;
		word_t             wdata;
		proc_reset = 1'b1;
		proc_read  = 1'b0;
		proc_write = 1'b0;
		proc_addr  = '0;
		proc_wdata = '0;
		mem_wait   = '0;
		lfsr_q     = 32'h2ce16f6e;
		errors     = 0;
		checks     = 0;
		for (int a = 0; a < NUM_WORDS; a++) begin
			golden[a] = fill_word(a);
		end
		for (int s = 0; s < NUM_SETS; s++) begin
			model_valid[s] = 1'b0;
			model_dirty[s] = 1'b0;
			model_tag[s]   = '0;
		end
		// outputs quiet during and right after reset
		repeat (3) begin
			@(posedge clk);
			check_true("stall or memory request active during reset",
				!proc_stall && !mem_read && !mem_write);
		end
		@(negedge clk);
		proc_reset = 1'b0;   // released after 3 cycles
		@(posedge clk);
		check_true("stall or memory request active after reset",
			!proc_stall && !mem_read && !mem_write);
		is_write = 1'b0;
		addr     = '0;
		wdata    = '0;
		for (int n = 0; n < NUM_REQ; n++) begin
			if (n > 0 && rand_bits(2) == 0) begin
				run_request(is_write, addr, wdata);   // repeat must hit
			end else begin
				is_write = rand_bits(1);
				line     = rand_bits(6);
				off      = rand_bits(2);
				addr     = {line[5:0], off[1:0]};
				wdata    = rand_bits(32);
				run_request(is_write, addr, wdata);
			end
		end
		@(negedge clk);
		proc_read  = 1'b0;
		proc_write = 1'b0;
		@(posedge clk);
		$display("requests %0d, checks %0d, errors %0d, memory model errors %0d",
			NUM_REQ, checks, errors, mem_errors);
		if (errors == 0 && mem_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	// watchdog sized for every request taking the worst miss path
	initial begin : watchdog
		#((NUM_REQ * WORST_CYC + 20) * CLK_PERIOD);
		$display("timeout: the cache stopped completing requests");
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* cache_top.f */
common/cache_pkg.sv
cache/cache_store.sv
cache/cache_ctrl.sv
src/cache_top.sv
test/mem_model.sv
test/tb_cache.sv

/* Bender.yml */
package:
  name: cache_top

sources:
  - common/cache_pkg.sv
  - cache/cache_store.sv
  - cache/cache_ctrl.sv
  - src/cache_top.sv
  - target: test
    files:
      - test/mem_model.sv
      - test/tb_cache.sv
